/* hdl/coef_fifo.sv */
// Show-ahead FIFO; writes while full and reads while empty are dropped, AFULL must be <= DEPTH
`timescale 1ns/1ps

module coef_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 32,
    parameter int  AFULL     = 28
) (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_wr,
    input  payload_t i_din,
    input  logic     i_rd,
    output payload_t o_dout,
    output logic     o_empty,
    output logic     o_full,
    output logic     o_afull
);

    localparam int AW = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is visible without a read
    assign o_dout  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == (AW + 1)'(DEPTH));
    assign o_afull = (count >= (AW + 1)'(AFULL));

endmodule

/* hdl/quant_coef_decode.sv */
// Pops only with room downstream for every result in flight; start is expected only while idle
`timescale 1ns/1ps

module quant_coef_decode (
    input  logic                   clk,
    input  logic                   i_rst,
    input  webp_quant_pkg::plane_t i_plane,
    input  logic                   i_start,
    input  logic                   i_empty,
    input  logic                   i_out_afull,
    input  webp_quant_pkg::coef_t  i_coef,
    output logic                   o_pop,
    output webp_quant_pkg::dec_t   o_dec,
    output logic                   o_dec_valid
);

    webp_quant_pkg::pos_t pos;
    logic                 pos_last;

    assign o_pop    = !i_empty && !i_out_afull;
    assign pos_last = (pos == webp_quant_pkg::pos_t'(webp_quant_pkg::BLOCK_LEN - 1));

    // Position within the 4x4 block
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pos         <= '0;
            o_dec_valid <= 1'b0;
        end else begin
            o_dec_valid <= o_pop;
            if (i_start) begin
                pos <= '0;
            end else if (o_pop) begin
                pos <= pos_last ? '0 : pos + 1'b1;
            end
        end
    end

    // Coefficient plus its table entry
    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_dec.coef <= i_coef;
            o_dec.pos  <= pos;
            o_dec.last <= pos_last;
            o_dec.qe   <= webp_quant_pkg::q_table(i_plane, pos);
        end
    end

endmodule

/* hdl/quant_execute.sv */
// Fixed two-cycle quantizer without stall; level clamps to +-MAX_LEVEL before dequantization
`timescale 1ns/1ps

module quant_execute (
    input  logic                    clk,
    input  logic                    i_rst,
    input  webp_quant_pkg::dec_t    i_dec,
    input  logic                    i_dec_valid,
    output webp_quant_pkg::result_t o_res,
    output logic                    o_res_valid
);

    logic [15:0] mag;
    logic [16:0] sharp_mag;

    logic                 s1_valid;
    logic                 s1_sign;
    logic                 s1_keep;
    logic [16:0]          s1_mag;
    logic [15:0]          s1_q;
    logic [15:0]          s1_iq;
    logic [31:0]          s1_bias;
    webp_quant_pkg::pos_t s1_pos;
    logic                 s1_last;

    logic [33:0]             acc;
    logic [33:0]             qdiv;
    logic [10:0]             lvl_mag;
    webp_quant_pkg::level_t  lvl;
    logic signed [28:0]      dq_full;

    // ------------------------------
    // Stage 1 sign, magnitude, dead zone
    assign mag       = i_dec.coef[15] ? 16'(-i_dec.coef) : 16'(i_dec.coef);
    assign sharp_mag = 17'(mag) + 17'(i_dec.qe.sharpen);

    always_ff @(posedge clk) begin
        s1_sign <= i_dec.coef[15];
        s1_keep <= 32'(sharp_mag) > i_dec.qe.zthresh;
        s1_mag  <= sharp_mag;
        s1_q    <= i_dec.qe.q;
        s1_iq   <= i_dec.qe.iq;
        s1_bias <= i_dec.qe.bias;
        s1_pos  <= i_dec.pos;
        s1_last <= i_dec.last;
    end

    // ------------------------------
    // Stage 2 divide by multiply, clamp, dequantize
    always_comb begin
        acc     = 34'(s1_mag) * 34'(s1_iq) + 34'(s1_bias);
        qdiv    = acc >> webp_quant_pkg::QFIX;
        lvl_mag = (qdiv > 34'(webp_quant_pkg::MAX_LEVEL)) ? 11'(webp_quant_pkg::MAX_LEVEL)
                                                           : qdiv[10:0];
        if (!s1_keep) begin
            lvl = '0;
        end else begin
            lvl = s1_sign ? -webp_quant_pkg::level_t'(lvl_mag)
                          : webp_quant_pkg::level_t'(lvl_mag);
        end
        dq_full = lvl * $signed({1'b0, s1_q});
    end

    always_ff @(posedge clk) begin
        o_res.level <= lvl;
        o_res.dq    <= webp_quant_pkg::dq_t'(dq_full);
        o_res.pos   <= s1_pos;
        o_res.last  <= s1_last;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            s1_valid    <= 1'b0;
            o_res_valid <= 1'b0;
        end else begin
            s1_valid    <= i_dec_valid;
            o_res_valid <= s1_valid;
        end
    end

endmodule

/* hdl/quant_reg_decode.sv */
// Register hub; plane changes are only safe while the input FIFO is empty and the pipeline idle
`timescale 1ns/1ps

module quant_reg_decode (
    input  logic                                  clk,
    input  logic                                  i_rst,
    input  logic                                  i_reg_wr,
    input  logic                                  i_reg_rd,
    input  logic [webp_quant_pkg::REG_ADDR_W-1:0] i_reg_addr,
    input  logic [webp_quant_pkg::REG_DATA_W-1:0] i_reg_wdata,
    output logic [webp_quant_pkg::REG_DATA_W-1:0] o_reg_rdata,
    input  logic [31:0]                           i_blocks,
    input  logic [31:0]                           i_nz,
    output webp_quant_pkg::plane_t                o_plane,
    output logic                                  o_start
);

    localparam int DW = webp_quant_pkg::REG_DATA_W;

    logic ctrl_wr;

    assign ctrl_wr = i_reg_wr && (i_reg_addr == webp_quant_pkg::REG_CTRL);

    // ------------------------------
    // Plane select and start pulse
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_plane <= webp_quant_pkg::Y1;
            o_start <= 1'b0;
        end else begin
            o_start <= ctrl_wr && i_reg_wdata[31];
            if (ctrl_wr) begin
                o_plane <= webp_quant_pkg::plane_t'(i_reg_wdata[1:0]);
            end
        end
    end

    // ------------------------------
    // Read data, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_reg_rdata <= '0;
        end else if (i_reg_rd) begin
            case (i_reg_addr)
                webp_quant_pkg::REG_CTRL:   o_reg_rdata <= DW'(o_plane);
                webp_quant_pkg::REG_BLOCKS: o_reg_rdata <= DW'(i_blocks);
                webp_quant_pkg::REG_NZ:     o_reg_rdata <= DW'(i_nz);
                default:                    o_reg_rdata <= '0;
            endcase
        end
    end

endmodule

/* hdl/quant_result.sv */
// Counters restart on start and wrap at 2^32; the output FIFO must keep room for results in flight
`timescale 1ns/1ps

module quant_result (
    input  logic                    clk,
    input  logic                    i_rst,
    input  webp_quant_pkg::result_t i_res,
    input  logic                    i_res_valid,
    input  logic                    i_start,
    output logic                    o_wr,
    output webp_quant_pkg::result_t o_din,
    output logic [31:0]             o_blocks,
    output logic [31:0]             o_nz
);

    // Output FIFO write port
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr <= 1'b0;
        end else begin
            o_wr <= i_res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_res_valid) begin
            o_din <= i_res;
        end
    end

    // ------------------------------
    // Status counters
    always_ff @(posedge clk) begin
        if (i_rst || i_start) begin
            o_blocks <= '0;
            o_nz     <= '0;
        end else if (i_res_valid) begin
            if (i_res.level != '0) begin
                o_nz <= o_nz + 32'd1;
            end
            if (i_res.last) begin
                o_blocks <= o_blocks + 32'd1;
            end
        end
    end

endmodule

/* hdl/webp_quant_pkg.sv */
// Shared types and fixed quantizer tables; the plane value 3 is not defined and reads as Y1
package webp_quant_pkg;

    typedef enum logic [1:0] {
        Y1 = 2'd0,
        Y2 = 2'd1,
        UV = 2'd2
    } plane_t;

    typedef logic signed [15:0] coef_t;
    typedef logic signed [11:0] level_t;
    typedef logic signed [17:0] dq_t;
    typedef logic [3:0]         pos_t;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
        logic [15:0] sharpen;
    } qentry_t;

    typedef struct packed {
        coef_t   coef;
        pos_t    pos;
        logic    last;
        qentry_t qe;
    } dec_t;

    typedef struct packed {
        level_t level;
        dq_t    dq;
        pos_t   pos;
        logic   last;
    } result_t;

    localparam int QFIX      = 17;
    localparam int MAX_LEVEL = 2047;
    localparam int BLOCK_LEN = 16;

    // Register map
    localparam int REG_ADDR_W = 2;
    localparam int REG_DATA_W = 32;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_BLOCKS = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_NZ     = 2'd2;

    // Y1 sharpen at positions 0-6, 8, 9 and 12
    localparam logic [15:0] Y1_SHARPEN = 16'h137F;

    // ------------------------------
    // Position 0 takes the DC entry, the rest take AC
    function automatic qentry_t q_table(plane_t plane, pos_t pos);
        qentry_t e;
        logic    dc;
        dc = (pos == '0);
        case (plane)
            Y2: begin
                e.q       = dc ? 16'h0030 : 16'h002E;
                e.iq      = dc ? 16'h0AAA : 16'h0B21;
                e.bias    = dc ? 32'hC000 : 32'hD800;
                e.zthresh = dc ? 32'h001E : 32'h001A;
                e.sharpen = '0;
            end
            UV: begin
                e.q       = dc ? 16'h0017 : 16'h001A;
                e.iq      = dc ? 16'h1642 : 16'h13B1;
                e.bias    = dc ? 32'hDC00 : 32'hE600;
                e.zthresh = dc ? 32'h000D : 32'h000E;
                e.sharpen = '0;
            end
            default: begin
                e.q       = dc ? 16'h0018 : 16'h001E;
                e.iq      = dc ? 16'h1555 : 16'h1111;
                e.bias    = dc ? 32'hC000 : 32'hDC00;
                e.zthresh = dc ? 32'h000F : 32'h0011;
                e.sharpen = {15'b0, Y1_SHARPEN[pos]};
            end
        endcase
        return e;
    endfunction

endpackage

/* hdl/webp_quant_top.sv */
// Writes while o_in_full are lost; the host must read o_out_data only while o_out_empty is low
`timescale 1ns/1ps

module webp_quant_top #(
    parameter int IN_DEPTH  = 32,
    parameter int OUT_DEPTH = 32
) (
    input  logic                                  clk,
    input  logic                                  i_rst,
    input  logic                                  i_reg_wr,
    input  logic                                  i_reg_rd,
    input  logic [webp_quant_pkg::REG_ADDR_W-1:0] i_reg_addr,
    input  logic [webp_quant_pkg::REG_DATA_W-1:0] i_reg_wdata,
    output logic [webp_quant_pkg::REG_DATA_W-1:0] o_reg_rdata,
    input  logic                                  i_coef_wr,
    input  webp_quant_pkg::coef_t                 i_coef,
    output logic                                  o_in_full,
    input  logic                                  i_out_rd,
    output webp_quant_pkg::result_t               o_out_data,
    output logic                                  o_out_empty
);

    // Room for every result between pop and FIFO write
    localparam int IN_AFULL  = IN_DEPTH - 4;
    localparam int OUT_AFULL = OUT_DEPTH - 4;

    webp_quant_pkg::plane_t  plane;
    logic                    start;
    logic [31:0]             blocks;
    logic [31:0]             nz;
    webp_quant_pkg::coef_t   in_dout;
    logic                    in_empty;
    logic                    in_pop;
    logic                    out_afull;
    webp_quant_pkg::dec_t    dec;
    logic                    dec_valid;
    webp_quant_pkg::result_t res;
    logic                    res_valid;
    webp_quant_pkg::result_t out_din;
    logic                    out_wr;

    quant_reg_decode reg_decode_i (
        .clk(clk), .i_rst(i_rst),
        .i_reg_wr(i_reg_wr), .i_reg_rd(i_reg_rd),
        .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata), .o_reg_rdata(o_reg_rdata),
        .i_blocks(blocks), .i_nz(nz), .o_plane(plane), .o_start(start)
    );

    coef_fifo #(
        .payload_t(webp_quant_pkg::coef_t), .DEPTH(IN_DEPTH), .AFULL(IN_AFULL)
    ) in_fifo_i (
        .clk(clk), .i_rst(i_rst), .i_wr(i_coef_wr), .i_din(i_coef), .i_rd(in_pop),
        .o_dout(in_dout), .o_empty(in_empty), .o_full(o_in_full), .o_afull()
    );

    quant_coef_decode coef_decode_i (
        .clk(clk), .i_rst(i_rst), .i_plane(plane), .i_start(start),
        .i_empty(in_empty), .i_out_afull(out_afull), .i_coef(in_dout),
        .o_pop(in_pop), .o_dec(dec), .o_dec_valid(dec_valid)
    );

    quant_execute execute_i (
        .clk(clk), .i_rst(i_rst), .i_dec(dec), .i_dec_valid(dec_valid),
        .o_res(res), .o_res_valid(res_valid)
    );

    quant_result result_i (
        .clk(clk), .i_rst(i_rst), .i_res(res), .i_res_valid(res_valid), .i_start(start),
        .o_wr(out_wr), .o_din(out_din), .o_blocks(blocks), .o_nz(nz)
    );

    coef_fifo #(
        .payload_t(webp_quant_pkg::result_t), .DEPTH(OUT_DEPTH), .AFULL(OUT_AFULL)
    ) out_fifo_i (
        .clk(clk), .i_rst(i_rst), .i_wr(out_wr), .i_din(out_din), .i_rd(i_out_rd),
        .o_dout(o_out_data), .o_empty(o_out_empty), .o_full(), .o_afull(out_afull)
    );

endmodule

/* tests/webp_quant_chk.sv */
// Bound checker; inputs that do not apply to a bind target are tied low and never fire
`timescale 1ns/1ps

module webp_quant_chk (
    input logic       clk,
    input logic       i_rst,
    input logic       i_wr,
    input logic       i_full,
    input logic       i_rd,
    input logic       i_empty,
    input logic       i_pop,
    input logic       i_afull,
    input logic [2:0] i_valid
);

    int errors = 0;

    a_no_wr_full: assert property (@(posedge clk) disable iff (i_rst) !(i_wr && i_full))
        else begin
            $error("FIFO written while full");
            errors++;
        end

    a_no_rd_empty: assert property (@(posedge clk) disable iff (i_rst) !(i_rd && i_empty))
        else begin
            $error("FIFO read while empty");
            errors++;
        end

    a_valid_known: assert property (@(posedge clk) disable iff (i_rst) !$isunknown(i_valid))
        else begin
            $error("pipeline valid bit unknown");
            errors++;
        end

    // Results in flight need the last four output slots
    a_no_pop_afull: assert property (@(posedge clk) disable iff (i_rst) !(i_pop && i_afull))
        else begin
            $error("input FIFO popped while output FIFO almost full");
            errors++;
        end

endmodule

bind coef_fifo webp_quant_chk fifo_chk_i (
    .clk(clk), .i_rst(i_rst), .i_wr(i_wr), .i_full(o_full), .i_rd(i_rd), .i_empty(o_empty),
    .i_pop(1'b0), .i_afull(1'b0), .i_valid(3'b000)
);

bind webp_quant_top webp_quant_chk top_chk_i (
    .clk(clk), .i_rst(i_rst), .i_wr(1'b0), .i_full(1'b0), .i_rd(1'b0), .i_empty(1'b0),
    .i_pop(in_pop), .i_afull(out_afull), .i_valid({dec_valid, res_valid, out_wr})
);

/* tests/webp_quant_tb.sv */
// Drives one plane at a time from an idle pipeline; expects 32-deep FIFOs and a 4-cycle pipeline
`timescale 1ns/1ps

module webp_quant_tb;

    // About 352 coefficients over all tests at up to 40 cycles each
    localparam int NUM_COEFS      = 8 * 16 + 8 * 16 + 2 * 16 + 64;
    localparam int TIMEOUT_CYCLES = NUM_COEFS * 40 + 6000;

    logic                                  clk;
    logic                                  i_rst;
    logic                                  i_reg_wr;
    logic                                  i_reg_rd;
    logic [webp_quant_pkg::REG_ADDR_W-1:0] i_reg_addr;
    logic [webp_quant_pkg::REG_DATA_W-1:0] i_reg_wdata;
    logic [webp_quant_pkg::REG_DATA_W-1:0] o_reg_rdata;
    logic                                  i_coef_wr;
    webp_quant_pkg::coef_t                 i_coef;
    logic                                  o_in_full;
    logic                                  i_out_rd;
    webp_quant_pkg::result_t               o_out_data;
    logic                                  o_out_empty;

    int                      seed;
    int                      cycles;
    string                   test_name;
    logic                    rd_en;
    webp_quant_pkg::plane_t  cur_plane;
    webp_quant_pkg::pos_t    tb_pos;
    int                      exp_nz;
    int                      exp_blocks;
    webp_quant_pkg::result_t exp_q[$];

    webp_quant_top #(
        .IN_DEPTH(32), .OUT_DEPTH(32)
    ) webp_quant_top_i (
        .clk(clk), .i_rst(i_rst),
        .i_reg_wr(i_reg_wr), .i_reg_rd(i_reg_rd), .i_reg_addr(i_reg_addr),
        .i_reg_wdata(i_reg_wdata), .o_reg_rdata(o_reg_rdata),
        .i_coef_wr(i_coef_wr), .i_coef(i_coef), .o_in_full(o_in_full),
        .i_out_rd(i_out_rd), .o_out_data(o_out_data), .o_out_empty(o_out_empty)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Reference quantizer
    function automatic webp_quant_pkg::result_t quant_ref(webp_quant_pkg::plane_t plane,
            webp_quant_pkg::pos_t pos, webp_quant_pkg::coef_t coef);
        webp_quant_pkg::qentry_t e;
        webp_quant_pkg::result_t r;
        longint                  mag;
        longint                  lvl;
        e   = webp_quant_pkg::q_table(plane, pos);
        mag = (coef < 0) ? -longint'(coef) : longint'(coef);
        mag = mag + longint'(e.sharpen);
        lvl = 0;
        // Dead zone unless strictly above zthresh
        if (mag > longint'(e.zthresh)) begin
            lvl = (mag * longint'(e.iq) + longint'(e.bias)) >> webp_quant_pkg::QFIX;
            if (lvl > webp_quant_pkg::MAX_LEVEL) begin
                lvl = webp_quant_pkg::MAX_LEVEL;
            end
            if (coef < 0) begin
                lvl = -lvl;
            end
        end
        r.level = webp_quant_pkg::level_t'(lvl);
        r.dq    = webp_quant_pkg::dq_t'(lvl * longint'(e.q));
        r.pos   = pos;
        r.last  = (pos == webp_quant_pkg::pos_t'(webp_quant_pkg::BLOCK_LEN - 1));
        return r;
    endfunction

    function automatic webp_quant_pkg::coef_t rand_coef();
        logic [31:0] r;
        r = $random(seed);
        return webp_quant_pkg::coef_t'(int'(r[12:0]) - 4096);
    endfunction

    function automatic int bound_errors();
        return webp_quant_top_i.top_chk_i.errors + webp_quant_top_i.in_fifo_i.fifo_chk_i.errors
            + webp_quant_top_i.out_fifo_i.fifo_chk_i.errors;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic check_eq(string name, logic [63:0] exp_v, logic [63:0] act_v);
        assert (exp_v === act_v) else begin
            fail_run($sformatf("** Error [%s] expected %0h actual %0h", name, exp_v, act_v));
        end
    endtask

    // ------------------------------
    // Host register and coefficient access
    task automatic reg_write(logic [1:0] addr, logic [31:0] data);
        @(negedge clk);
        i_reg_wr    = 1'b1;
        i_reg_addr  = addr;
        i_reg_wdata = data;
        @(negedge clk);
        i_reg_wr = 1'b0;
    endtask

    task automatic reg_read(logic [1:0] addr, output logic [31:0] data);
        @(negedge clk);
        i_reg_rd   = 1'b1;
        i_reg_addr = addr;
        @(negedge clk);
        i_reg_rd = 1'b0;
        data     = o_reg_rdata;
    endtask

    task automatic start_plane(webp_quant_pkg::plane_t p);
        reg_write(webp_quant_pkg::REG_CTRL, 32'h8000_0000 | 32'(p));
        cur_plane  = p;
        tb_pos     = '0;
        exp_nz     = 0;
        exp_blocks = 0;
    endtask

    // Caller holds the negedge
    task automatic record_push(webp_quant_pkg::coef_t c);
        webp_quant_pkg::result_t r;
        r         = quant_ref(cur_plane, tb_pos, c);
        i_coef_wr = 1'b1;
        i_coef    = c;
        exp_q.push_back(r);
        if (r.level != '0) exp_nz++;
        if (r.last) exp_blocks++;
        tb_pos++;
    endtask

    task automatic push_coef(webp_quant_pkg::coef_t c);
        @(negedge clk);
        i_coef_wr = 1'b0;
        while (o_in_full) @(negedge clk);
        record_push(c);
    endtask

    task automatic check_status();
        logic [31:0] v;
        reg_read(webp_quant_pkg::REG_BLOCKS, v);
        check_eq({test_name, " blocks"}, 64'(exp_blocks), v);
        reg_read(webp_quant_pkg::REG_NZ, v);
        check_eq({test_name, " nonzero"}, 64'(exp_nz), v);
    endtask

    task automatic drain_and_check();
        @(negedge clk);
        i_coef_wr = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        assert (o_out_empty) else fail_run("output FIFO holds a result nobody expected");
        check_status();
    endtask

    // ------------------------------
    // Comparing process reads whenever a result is shown
    initial begin : compare_results
        webp_quant_pkg::result_t exp_res;
        i_out_rd = 1'b0;
        forever begin
            @(negedge clk);
            i_out_rd = 1'b0;
            if (!i_rst && rd_en && !o_out_empty) begin
                assert (exp_q.size() != 0) else fail_run("DUT produced an unexpected result");
                exp_res = exp_q.pop_front();
                check_eq({test_name, " result"}, 64'(exp_res), 64'(o_out_data));
                i_out_rd = 1'b1;
            end
        end
    end

    initial begin : bound_monitor
        forever begin
            @(posedge clk);
            if (bound_errors() != 0) begin
                fail_run("a bound assertion on a FIFO or the pipeline failed");
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with results still outstanding", cycles);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on timeout");
    end

    initial begin : run_tests
        webp_quant_pkg::qentry_t e;
        logic [31:0]             rdata;
        int                      n;
        seed        = 32'h04a9_344d;
        i_rst       = 1'b1;
        i_reg_wr    = 1'b0;
        i_reg_rd    = 1'b0;
        i_reg_addr  = '0;
        i_reg_wdata = '0;
        i_coef_wr   = 1'b0;
        i_coef      = '0;
        rd_en       = 1'b1;
        cur_plane   = webp_quant_pkg::Y1;
        tb_pos      = '0;
        exp_nz      = 0;
        exp_blocks  = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;

        test_name = "registers";
        check_status();
        start_plane(webp_quant_pkg::UV);
        reg_read(webp_quant_pkg::REG_CTRL, rdata);
        check_eq(test_name, 64'(webp_quant_pkg::UV), rdata);

        test_name = "y1_random";
        start_plane(webp_quant_pkg::Y1);
        repeat (8 * 16) push_coef(rand_coef());
        drain_and_check();

        test_name = "y2_random";
        start_plane(webp_quant_pkg::Y2);
        repeat (4 * 16) push_coef(rand_coef());
        drain_and_check();
        test_name = "uv_random";
        start_plane(webp_quant_pkg::UV);
        repeat (4 * 16) push_coef(rand_coef());
        drain_and_check();

        // Exactly on zthresh, then full-scale inputs
        test_name = "threshold_clamp";
        start_plane(webp_quant_pkg::Y1);
        for (int p = 0; p < 16; p++) begin
            e = webp_quant_pkg::q_table(webp_quant_pkg::Y1, webp_quant_pkg::pos_t'(p));
            n = int'(e.zthresh) - int'(e.sharpen);
            push_coef(webp_quant_pkg::coef_t'(p[0] ? -n : n));
        end
        for (int p = 0; p < 16; p++) begin
            push_coef(p[0] ? -16'sd32767 : 16'sd32767);
        end
        drain_and_check();

        // Stop reading until the input FIFO fills
        test_name = "back_pressure";
        start_plane(webp_quant_pkg::Y1);
        rd_en = 1'b0;
        n     = 0;
        @(negedge clk);
        while (!o_in_full && n < 100) begin
            record_push(rand_coef());
            n++;
            @(negedge clk);
        end
        i_coef_wr = 1'b0;
        assert (o_in_full) else fail_run("input FIFO never filled while the host held off reads");
        rd_en = 1'b1;
        drain_and_check();

        if (bound_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("Bound assertions failed %0d times", bound_errors());
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/webp_quant_pkg.sv
hdl/coef_fifo.sv
hdl/quant_reg_decode.sv
hdl/quant_coef_decode.sv
hdl/quant_execute.sv
hdl/quant_result.sv
hdl/webp_quant_top.sv
tests/webp_quant_chk.sv
tests/webp_quant_tb.sv
